// File: run.sh
#!/usr/bin/env bash
# Build and run the debug hub testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_dbg -f tb.f -o tb_dbg_sim
./obj_dir/tb_dbg_sim 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// File: source/dbg_bus_module.sv
// Bus debug peer: command decode, bus request FSM, read-data output shift register
`timescale 1ns/100ps

module dbg_bus_module (
  input  logic                      tck_i,
  input  logic                      rst_i,
  input  logic                      tdi_i,
  input  logic                      shift_dr_i,
  input  logic                      capture_dr_i,
  input  logic                      update_dr_i,
  input  logic                      module_select_i,
  input  logic [dbg_pkg::DR_LEN-1:0] data_reg_i,
  output logic                      module_tdo_o,
  output logic                      top_inhibit_o,
  // Request/acknowledge bus
  output logic                      bus_req_o,
  output logic                      bus_we_o,
  output logic [31:0]               bus_addr_o,
  output logic [31:0]               bus_wdata_o,
  input  logic [31:0]               bus_rdata_i,
  input  logic                      bus_ack_i
);
  import dbg_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_WDATA,
    ST_BUS_REQ,
    ST_READ_READY
  } state_e;

  state_e             state_q;
  bus_op_e            cmd_op;
  bus_op_e            op_q;
  logic               cmd_valid;
  logic               update_sel;
  logic [31:0]        addr_q;
  logic [31:0]        wdata_q;
  logic [31:0]        rdata_q;
  logic               done_q;
  logic [OUT_LEN-1:0] out_sr;

  //////////////////////////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////////////////////////

  // Update strobe while this peer owns the chain
  assign update_sel = update_dr_i && module_select_i;
  // Plain command, select flag clear
  assign cmd_valid  = update_sel && !data_reg_i[SEL_BIT];
  assign cmd_op     = bus_op_e'(data_reg_i[OPCODE_MSB:OPCODE_LSB]);

  // Transaction FSM
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      op_q    <= BUS_NOP;
      done_q  <= 1'b0;
      rdata_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cmd_valid) begin
            op_q   <= cmd_op;
            done_q <= 1'b0;
            case (cmd_op)
              BUS_WRITE32: state_q <= ST_WAIT_WDATA;
              BUS_READ32:  state_q <= ST_BUS_REQ;
              default:     state_q <= ST_IDLE;
            endcase
          end
        end
        // Any update here ends the data scan, select flag included
        ST_WAIT_WDATA: begin
          if (update_sel) begin
            state_q <= ST_BUS_REQ;
          end
        end
        // Request held until ack, drops next cycle
        ST_BUS_REQ: begin
          if (bus_ack_i) begin
            done_q <= 1'b1;
            if (op_q == BUS_READ32) begin
              rdata_q <= bus_rdata_i;
              state_q <= ST_READ_READY;
            end else begin
              state_q <= ST_IDLE;
            end
          end
        end
        // Waiting for the capture of the read result
        ST_READ_READY: begin
          if (capture_dr_i && module_select_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Address on the command, write data on the data scan
  always_ff @(posedge tck_i) begin
    if (state_q == ST_IDLE && cmd_valid) begin
      addr_q <= data_reg_i[ADDR_MSB:ADDR_LSB];
    end
    if (state_q == ST_WAIT_WDATA && update_sel) begin
      wdata_q <= data_reg_i[DR_LEN-1 -: DATA_LEN];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus outputs and TDO
  //////////////////////////////////////////////////////////////////////

  assign bus_req_o     = (state_q == ST_BUS_REQ);
  assign bus_we_o      = bus_req_o && (op_q == BUS_WRITE32);
  assign bus_addr_o    = addr_q;
  assign bus_wdata_o   = wdata_q;
  // Open from command until ack or capture
  assign top_inhibit_o = (state_q != ST_IDLE);

  // Done flag first, then data LSB first
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_sr <= '0;
    end else if (capture_dr_i && module_select_i) begin
      out_sr <= {rdata_q, done_q};
    end else if (shift_dr_i && module_select_i) begin
      out_sr <= {tdi_i, out_sr[OUT_LEN-1:1]};
    end
  end

  assign module_tdo_o = out_sr[0];

endmodule

// File: source/dbg_cpu_module.sv
// CPU debug peer: stall/reset control, breakpoint stall, status readback register
`timescale 1ns/100ps

module dbg_cpu_module (
  input  logic                      tck_i,
  input  logic                      rst_i,
  input  logic                      tdi_i,
  input  logic                      shift_dr_i,
  input  logic                      capture_dr_i,
  input  logic                      update_dr_i,
  input  logic                      module_select_i,
  input  logic [dbg_pkg::DR_LEN-1:0] data_reg_i,
  output logic                      module_tdo_o,
  output logic                      top_inhibit_o,
  // CPU control levels
  output logic                      cpu_stall_o,
  output logic                      cpu_rst_o,
  input  logic                      cpu_bp_i
);
  import dbg_pkg::*;

  // Write data scan outstanding or not
  typedef enum logic {
    PEND_NONE,
    PEND_WDATA
  } pend_e;

  pend_e               pend_q;
  cpu_op_e             cmd_op;
  logic                update_sel;
  logic                cmd_valid;
  logic                read_pend_q;
  logic                stall_q;
  logic                rst_q;
  logic                bp_q;
  logic                bp_rise;
  logic                bp_flag_q;
  logic [DATA_LEN-1:0] wdata;
  logic [DATA_LEN-1:0] status;
  logic [OUT_LEN-1:0]  out_sr;

  assign update_sel = update_dr_i && module_select_i;
  // New command only when nothing is open
  assign cmd_valid  = update_sel && !data_reg_i[SEL_BIT] && (pend_q == PEND_NONE)
                      && !read_pend_q;
  assign cmd_op     = cpu_op_e'(data_reg_i[OPCODE_MSB:OPCODE_LSB]);
  assign wdata      = data_reg_i[DR_LEN-1 -: DATA_LEN];

  // Breakpoint edge
  assign bp_rise = cpu_bp_i && !bp_q;

  //////////////////////////////////////////////////////////////////////
  // Command and control state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      pend_q      <= PEND_NONE;
      read_pend_q <= 1'b0;
      stall_q     <= 1'b0;
      rst_q       <= 1'b0;
      bp_q        <= 1'b0;
      bp_flag_q   <= 1'b0;
    end else begin
      bp_q <= cpu_bp_i;
      if (cmd_valid && cmd_op == CPU_WRITE_CTRL) begin
        pend_q <= PEND_WDATA;
      end
      if (cmd_valid && cmd_op == CPU_READ_CTRL) begin
        read_pend_q <= 1'b1;
      end
      // Data scan of a control write, breakpoint still wins on stall
      if (pend_q == PEND_WDATA && update_sel) begin
        pend_q    <= PEND_NONE;
        stall_q   <= wdata[CPU_CTRL_STALL_BIT] | bp_rise;
        rst_q     <= wdata[CPU_CTRL_RESET_BIT];
        bp_flag_q <= bp_rise;
      end else if (bp_rise) begin
        stall_q   <= 1'b1;
        bp_flag_q <= 1'b1;
      end
      // Read completes at its capture
      if (capture_dr_i && module_select_i) begin
        read_pend_q <= 1'b0;
      end
    end
  end

  assign cpu_stall_o   = stall_q;
  assign cpu_rst_o     = rst_q;
  assign top_inhibit_o = (pend_q != PEND_NONE) || read_pend_q;

  //////////////////////////////////////////////////////////////////////
  // Status readback
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    status                     = '0;
    status[CPU_CTRL_STALL_BIT] = stall_q;
    status[CPU_CTRL_RESET_BIT] = rst_q;
    status[CPU_STATUS_BP_BIT]  = bp_flag_q;
  end

  // Same format as the bus read, done flag at bit 0
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_sr <= '0;
    end else if (capture_dr_i && module_select_i) begin
      out_sr <= {status, read_pend_q};
    end else if (shift_dr_i && module_select_i) begin
      out_sr <= {tdi_i, out_sr[OUT_LEN-1:1]};
    end
  end

  assign module_tdo_o = out_sr[0];

endmodule

// File: source/dbg_hub.sv
// Debug hub top: DR input shift register, module select with inhibit, TDO mux, peers
`timescale 1ns/100ps

module dbg_hub (
  // JTAG side
  input  logic        tck_i,
  input  logic        rst_i,
  input  logic        tdi_i,
  input  logic        shift_dr_i,
  input  logic        pause_dr_i,
  input  logic        update_dr_i,
  input  logic        capture_dr_i,
  input  logic        debug_select_i,
  output logic        tdo_o,
  // Memory bus master
  output logic        bus_req_o,
  output logic        bus_we_o,
  output logic [31:0] bus_addr_o,
  output logic [31:0] bus_wdata_o,
  input  logic [31:0] bus_rdata_i,
  input  logic        bus_ack_i,
  // CPU control
  output logic        cpu_stall_o,
  output logic        cpu_rst_o,
  input  logic        cpu_bp_i
);
  import dbg_pkg::*;

  logic [DR_LEN-1:0] data_reg;
  module_id_e        module_id_q;
  module_id_e        module_id_in;
  logic              select_cmd;
  logic              select_inhibit;
  // Per-peer select, TDO and inhibit
  logic              bus_select;
  logic              cpu_select;
  logic              bus_tdo;
  logic              cpu_tdo;
  logic              bus_inhibit;
  logic              cpu_inhibit;

  //////////////////////////////////////////////////////////////////////
  // Input shift register and module select
  //////////////////////////////////////////////////////////////////////

  // New bits enter at the top, first bit ends at bit 0
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      data_reg <= '0;
    end else if (debug_select_i && shift_dr_i && !pause_dr_i) begin
      data_reg <= {tdi_i, data_reg[DR_LEN-1:1]};
    end
  end

  // Select flag and module ID field right below it
  assign select_cmd   = data_reg[SEL_BIT];
  assign module_id_in = module_id_e'(data_reg[SEL_BIT-1 -: MODULE_ID_LEN]);

  // Any open peer transaction blocks reselection
  assign select_inhibit = bus_inhibit | cpu_inhibit;

  // Owner changes only at the update of a select scan
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      module_id_q <= MOD_BUS;
    end else if (debug_select_i && select_cmd && update_dr_i && !select_inhibit) begin
      module_id_q <= module_id_in;
    end
  end

  // One-hot selects, qualified by the debug IR
  assign bus_select = debug_select_i && (module_id_q == MOD_BUS);
  assign cpu_select = debug_select_i && (module_id_q == MOD_CPU);

  //////////////////////////////////////////////////////////////////////
  // Peers
  //////////////////////////////////////////////////////////////////////

  dbg_bus_module u_bus (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .shift_dr_i     (shift_dr_i),
    .capture_dr_i   (capture_dr_i),
    .update_dr_i    (update_dr_i),
    .module_select_i(bus_select),
    .data_reg_i     (data_reg),
    .module_tdo_o   (bus_tdo),
    .top_inhibit_o  (bus_inhibit),
    .bus_req_o      (bus_req_o),
    .bus_we_o       (bus_we_o),
    .bus_addr_o     (bus_addr_o),
    .bus_wdata_o    (bus_wdata_o),
    .bus_rdata_i    (bus_rdata_i),
    .bus_ack_i      (bus_ack_i)
  );

  dbg_cpu_module u_cpu (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .shift_dr_i     (shift_dr_i),
    .capture_dr_i   (capture_dr_i),
    .update_dr_i    (update_dr_i),
    .module_select_i(cpu_select),
    .data_reg_i     (data_reg),
    .module_tdo_o   (cpu_tdo),
    .top_inhibit_o  (cpu_inhibit),
    .cpu_stall_o    (cpu_stall_o),
    .cpu_rst_o      (cpu_rst_o),
    .cpu_bp_i       (cpu_bp_i)
  );

  // TDO follows the owner, reserved IDs read 0
  always_comb begin
    case (module_id_q)
      MOD_BUS: tdo_o = bus_tdo;
      MOD_CPU: tdo_o = cpu_tdo;
      default: tdo_o = 1'b0;
    endcase
  end

endmodule

// File: source/dbg_pkg.sv
// Debug hub package: DR widths, field positions, module ID and opcode enums
package dbg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data register layout
  //////////////////////////////////////////////////////////////////////

  // Full input shift register
  localparam int DR_LEN        = 53;
  localparam int MODULE_ID_LEN = 2;

  // Select flag at the top, opcode below it
  localparam int SEL_BIT    = 52;
  localparam int OPCODE_MSB = 51;
  localparam int OPCODE_LSB = 48;

  // 32-bit address after the opcode
  localparam int ADDR_MSB = 47;
  localparam int ADDR_LSB = 16;

  // Data word, top 32 bits of the DR in a data scan
  localparam int DATA_LEN = 32;

  // Output register of a peer, done flag plus data word
  localparam int OUT_LEN = DATA_LEN + 1;

  // CPU control and status bits
  localparam int CPU_CTRL_STALL_BIT = 0;
  localparam int CPU_CTRL_RESET_BIT = 1;
  localparam int CPU_STATUS_BP_BIT  = 2;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Owner of the chain, 2 and 3 reserved
  typedef enum logic [MODULE_ID_LEN-1:0] {
    MOD_BUS   = 2'd0,
    MOD_CPU   = 2'd1,
    MOD_RSVD2 = 2'd2,
    MOD_RSVD3 = 2'd3
  } module_id_e;

  // Bus peer opcodes
  typedef enum logic [3:0] {
    BUS_NOP     = 4'h0,
    BUS_WRITE32 = 4'h3,
    BUS_READ32  = 4'h7
  } bus_op_e;

  // CPU peer opcodes
  typedef enum logic [3:0] {
    CPU_NOP        = 4'h0,
    CPU_WRITE_CTRL = 4'h4,
    CPU_READ_CTRL  = 4'h5
  } cpu_op_e;

endpackage

// File: tb.f
source/dbg_pkg.sv
source/dbg_bus_module.sv
source/dbg_cpu_module.sv
source/dbg_hub.sv
tests/tb_clock_gen.sv
tests/dbg_asserts.sv
tests/tb_dbg.sv

// File: tests/dbg_asserts.sv
// Bound checks on the bus debug peer: request hold until ack, inhibit, idle bus in reset
`timescale 1ns/100ps

module dbg_asserts (
  input logic        tck_i,
  input logic        rst_i,
  input logic        bus_req_i,
  input logic        bus_we_i,
  input logic        bus_ack_i,
  input logic [31:0] bus_addr_i,
  input logic [31:0] bus_wdata_i,
  input logic        top_inhibit_i
);

  // Request level holds, with address, we and data, until ack
  req_hold: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_req_i && !bus_ack_i |=> bus_req_i && $stable(bus_addr_i) && $stable(bus_we_i)
                                && $stable(bus_wdata_i))
    else $error("bus request dropped or changed before ack");

  // Open transfer keeps reselection blocked
  req_inhibit: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_req_i |-> top_inhibit_i)
    else $error("bus request without top inhibit");

  // No bus traffic while reset is held
  req_reset: assert property (@(posedge tck_i) rst_i |-> !bus_req_i)
    else $error("bus request high during reset");

endmodule

bind dbg_bus_module dbg_asserts u_asserts (
  .tck_i        (tck_i),
  .rst_i        (rst_i),
  .bus_req_i    (bus_req_o),
  .bus_we_i     (bus_we_o),
  .bus_ack_i    (bus_ack_i),
  .bus_addr_i   (bus_addr_o),
  .bus_wdata_i  (bus_wdata_o),
  .top_inhibit_i(top_inhibit_o)
);

// File: tests/tb_clock_gen.sv
// Testbench clock and reset source, 40 ns TCK with reset held for 5 cycles
`timescale 1ns/100ps

module tb_clock_gen (
  output logic tck_o,
  output logic rst_o
);

  // 40 ns period
  initial begin
    tck_o = 1'b0;
    forever #20 tck_o = ~tck_o;
  end

  // Reset rises just after time 0 so the async edge is seen
  initial begin
    rst_o = 1'b0;
    #1;
    rst_o = 1'b1;
    repeat (5) @(posedge tck_o);
    rst_o <= 1'b0;
  end

endmodule

// File: tests/tb_dbg.sv
// Testbench top: JTAG DR scan tasks, bus memory model, stimulus table loop, error summary
`timescale 1ns/100ps

module tb_dbg;
  import dbg_pkg::*;

  typedef enum logic [2:0] {
    K_SELECT, K_BUS_WRITE, K_BUS_READ, K_SEL_INHIBIT,
    K_CPU_WRITE, K_CPU_READ, K_BP_PULSE, K_RAW_READ
  } kind_e;

  // One table row per operation
  typedef struct packed {
    kind_e       kind;
    logic [1:0]  mod_id;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_val;
  } row_t;

  logic        tck, rst, tdi, tdo;
  logic        shift_dr, pause_dr, update_dr, capture_dr, debug_select;
  logic        bus_req, bus_we, bus_ack;
  logic [31:0] bus_addr, bus_wdata, bus_rdata;
  logic        cpu_stall, cpu_rst, cpu_bp;
  logic [31:0] mem [0:63];
  int          ack_count, delay_left, err_cnt, check_cnt, timeout_cnt;
  logic        busy, seeded;
  row_t        rows[$];
  string       names[$];

  tb_clock_gen u_clk (.tck_o(tck), .rst_o(rst));

  dbg_hub UUT (
    .tck_i(tck), .rst_i(rst), .tdi_i(tdi), .shift_dr_i(shift_dr), .pause_dr_i(pause_dr),
    .update_dr_i(update_dr), .capture_dr_i(capture_dr), .debug_select_i(debug_select),
    .tdo_o(tdo), .bus_req_o(bus_req), .bus_we_o(bus_we), .bus_addr_o(bus_addr),
    .bus_wdata_o(bus_wdata), .bus_rdata_i(bus_rdata), .bus_ack_i(bus_ack),
    .cpu_stall_o(cpu_stall), .cpu_rst_o(cpu_rst), .cpu_bp_i(cpu_bp)
  );

  // Power-on memory contents, every word distinct
  function automatic logic [31:0] fill_word(input int idx);
    return 32'hC3A5_0F00 ^ (32'(idx) * 32'h0101_0101);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Memory model, ack after 0 to 3 extra cycles
  //////////////////////////////////////////////////////////////////////

  always @(posedge tck or posedge rst) begin
    if (rst) begin
      if (!seeded) begin
        void'($urandom(22));
        seeded   = 1'b1;
      end
      busy       = 1'b0;
      delay_left = 0;
      bus_ack   <= 1'b0;
      bus_rdata <= '0;
      ack_count <= 0;
      for (int i = 0; i < 64; i++) begin
        mem[i] <= fill_word(i);
      end
    end else begin
      bus_ack <= 1'b0;
      if (bus_req && !bus_ack) begin
        // New request, pick its latency
        if (!busy) begin
          busy       = 1'b1;
          delay_left = int'($urandom % 4);
        end
        if (delay_left == 0) begin
          busy       = 1'b0;
          bus_ack   <= 1'b1;
          bus_rdata <= mem[bus_addr[7:2]];
          ack_count <= ack_count + 1;
          if (bus_we) begin
            mem[bus_addr[7:2]] <= bus_wdata;
          end
        end else begin
          delay_left = delay_left - 1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // DR words and scan tasks
  //////////////////////////////////////////////////////////////////////

  function automatic logic [DR_LEN-1:0] select_word(input logic [1:0] id);
    logic [DR_LEN-1:0] w;
    w = '0;
    w[SEL_BIT] = 1'b1;
    w[SEL_BIT-1 -: MODULE_ID_LEN] = id;
    return w;
  endfunction

  function automatic logic [DR_LEN-1:0] cmd_word(input logic [3:0] op, input logic [31:0] a);
    logic [DR_LEN-1:0] w;
    w = '0;
    w[OPCODE_MSB:OPCODE_LSB] = op;
    w[ADDR_MSB:ADDR_LSB] = a;
    return w;
  endfunction

  // Data word in the top 32 bits
  function automatic logic [DR_LEN-1:0] data_word(input logic [31:0] d);
    return {d, {(DR_LEN-DATA_LEN){1'b0}}};
  endfunction

  // Bit 0 first, then update_dr for one cycle
  task automatic scan_dr(input logic [DR_LEN-1:0] word);
    for (int i = 0; i < DR_LEN; i++) begin
      @(posedge tck);
      shift_dr <= 1'b1;
      tdi      <= word[i];
    end
    @(posedge tck);
    shift_dr  <= 1'b0;
    tdi       <= 1'b0;
    update_dr <= 1'b1;
    @(posedge tck);
    update_dr <= 1'b0;
  endtask

  // Capture, then sample TDO ahead of each shift
  task automatic read_out(output logic [OUT_LEN-1:0] bits);
    @(posedge tck);
    capture_dr <= 1'b1;
    @(posedge tck);
    capture_dr <= 1'b0;
    shift_dr   <= 1'b1;
    // Ones follow the read word into the peer register
    tdi        <= 1'b1;
    for (int i = 0; i < OUT_LEN; i++) begin
      @(negedge tck);
      bits[i] = tdo;
      @(posedge tck);
    end
    shift_dr <= 1'b0;
    tdi      <= 1'b0;
  endtask

  task automatic check_value(input string name, input logic [32:0] exp_v,
                             input logic [32:0] act_v);
    check_cnt++;
    assert (act_v === exp_v) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic wait_ack(input int start_cnt, input string name);
    int cycles;
    cycles = 0;
    while (ack_count == start_cnt && cycles < 200) begin
      @(negedge tck);
      cycles++;
    end
    if (ack_count == start_cnt) begin
      $display("Timeout: no bus acknowledge within 200 cycles in %s", name);
      timeout_cnt++;
    end
  endtask

  task automatic wait_stall(input string name);
    int cycles;
    cycles = 0;
    while (!cpu_stall && cycles < 200) begin
      @(negedge tck);
      cycles++;
    end
    if (!cpu_stall) begin
      $display("Timeout: cpu_stall_o stayed low for 200 cycles in %s", name);
      timeout_cnt++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Table rows
  //////////////////////////////////////////////////////////////////////

  task automatic add_row(input kind_e kind, input logic [1:0] id, input logic [31:0] addr,
                         input logic [31:0] data, input logic [31:0] exp_val, input string name);
    row_t r;
    r.kind    = kind;
    r.mod_id  = id;
    r.addr    = addr;
    r.data    = data;
    r.exp_val = exp_val;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic run_row(input row_t r, input string name);
    logic [OUT_LEN-1:0] bits;
    int                 snap;
    snap = ack_count;
    case (r.kind)
      K_SELECT: scan_dr(select_word(r.mod_id));
      // Inhibit case: the data scan is itself a select scan
      K_BUS_WRITE, K_SEL_INHIBIT: begin
        scan_dr(cmd_word(BUS_WRITE32, r.addr));
        scan_dr(data_word(r.data));
        wait_ack(snap, name);
        check_value(name, {1'b0, r.exp_val}, {1'b0, mem[r.addr[7:2]]});
      end
      // Done flag must read 1 below the data
      K_BUS_READ: begin
        scan_dr(cmd_word(BUS_READ32, r.addr));
        wait_ack(snap, name);
        read_out(bits);
        check_value(name, {r.exp_val, 1'b1}, bits);
      end
      K_CPU_WRITE: begin
        scan_dr(cmd_word(CPU_WRITE_CTRL, 32'h0));
        scan_dr(data_word(r.data));
        @(negedge tck);
        check_value(name, {1'b0, r.exp_val}, {31'b0, cpu_rst, cpu_stall});
      end
      K_CPU_READ: begin
        scan_dr(cmd_word(CPU_READ_CTRL, 32'h0));
        read_out(bits);
        check_value(name, {r.exp_val, 1'b1}, bits);
      end
      K_BP_PULSE: begin
        @(posedge tck);
        cpu_bp <= 1'b1;
        @(posedge tck);
        cpu_bp <= 1'b0;
        wait_stall(name);
        check_value(name, {1'b0, r.exp_val}, {31'b0, cpu_rst, cpu_stall});
      end
      // No command, just what TDO carries
      K_RAW_READ: begin
        read_out(bits);
        check_value(name, {r.exp_val, 1'b0}, bits);
      end
      default: ;
    endcase
  endtask

  initial begin
    int cycles;
    tdi          = 1'b0;
    shift_dr     = 1'b0;
    pause_dr     = 1'b0;
    update_dr    = 1'b0;
    capture_dr   = 1'b0;
    debug_select = 1'b0;
    cpu_bp       = 1'b0;
    err_cnt      = 0;
    check_cnt    = 0;
    timeout_cnt  = 0;
    seeded       = 1'b0;
    cycles       = 0;
    do begin
      @(negedge tck);
      cycles++;
    end while (rst && cycles < 200);
    if (rst) begin
      $display("Timeout: reset never released");
      timeout_cnt++;
    end
    // Outputs idle after reset
    check_value("reset_outputs", 33'h0, {30'b0, bus_req, cpu_stall, cpu_rst});
    @(posedge tck);
    debug_select <= 1'b1;

    // Module ID resets to MOD_BUS, no select needed
    add_row(K_BUS_READ,    MOD_BUS,   32'h10, 32'h0,         fill_word(4),  "rd_after_reset");
    add_row(K_SELECT,      MOD_BUS,   32'h0,  32'h0,         32'h0,         "sel_bus");
    add_row(K_BUS_WRITE,   MOD_BUS,   32'h00, 32'h1234_5678, 32'h1234_5678, "wr_00");
    add_row(K_BUS_WRITE,   MOD_BUS,   32'h04, 32'hDEAD_BEEF, 32'hDEAD_BEEF, "wr_04");
    add_row(K_BUS_WRITE,   MOD_BUS,   32'h3C, 32'h0F0F_A5A5, 32'h0F0F_A5A5, "wr_3c");
    add_row(K_BUS_READ,    MOD_BUS,   32'h00, 32'h0,         32'h1234_5678, "rd_00");
    add_row(K_BUS_READ,    MOD_BUS,   32'h04, 32'h0,         32'hDEAD_BEEF, "rd_04");
    add_row(K_BUS_READ,    MOD_BUS,   32'h3C, 32'h0,         32'h0F0F_A5A5, "rd_3c");
    // Top bits 1 and 01 make a select for MOD_CPU, blocked by the open write
    add_row(K_SEL_INHIBIT, MOD_CPU,   32'h20, 32'hA5C3_3C5A, 32'hA5C3_3C5A, "sel_inhibit");
    add_row(K_BUS_READ,    MOD_BUS,   32'h20, 32'h0,         32'hA5C3_3C5A, "rd_20_still_bus");
    add_row(K_SELECT,      MOD_CPU,   32'h0,  32'h0,         32'h0,         "sel_cpu");
    add_row(K_CPU_WRITE,   MOD_CPU,   32'h0,  32'h3,         32'h3,         "cpu_stall_rst");
    add_row(K_CPU_READ,    MOD_CPU,   32'h0,  32'h0,         32'h3,         "cpu_status_3");
    add_row(K_CPU_WRITE,   MOD_CPU,   32'h0,  32'h0,         32'h0,         "cpu_clear");
    add_row(K_CPU_READ,    MOD_CPU,   32'h0,  32'h0,         32'h0,         "cpu_status_0");
    add_row(K_BP_PULSE,    MOD_CPU,   32'h0,  32'h0,         32'h1,         "bp_stall");
    // Stall plus breakpoint flag
    add_row(K_CPU_READ,    MOD_CPU,   32'h0,  32'h0,         32'h5,         "cpu_status_bp");
    add_row(K_SELECT,      MOD_RSVD2, 32'h0,  32'h0,         32'h0,         "sel_rsvd2");
    add_row(K_RAW_READ,    MOD_RSVD2, 32'h0,  32'h0,         32'h0,         "rsvd2_tdo_zero");
    add_row(K_SELECT,      MOD_BUS,   32'h0,  32'h0,         32'h0,         "sel_bus_again");
    add_row(K_BUS_READ,    MOD_BUS,   32'h04, 32'h0,         32'hDEAD_BEEF, "rd_04_back");

    for (int i = 0; i < rows.size(); i++) begin
      run_row(rows[i], names[i]);
    end

    $display("Summary: %0d checks, %0d value errors, %0d timeouts",
             check_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
